// File: all.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/mips_core.sv
tests/mips_core_asserts.sv
tests/mips_core_tb.sv

// File: rtl/decode_stage.sv
// control decode, register file, load-use detection and the ID/EX register
`include "mips_params.svh"

module decode_stage import mips_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     flush,
	input  word_t    if_pc4,
	input  instr_t   if_instr,
	input  logic     wb_we,
	input  reg_idx_t wb_reg,
	input  word_t    wb_data,
	output logic     stall,
	output word_t    id_pc4,
	output word_t    id_rs_val,
	output word_t    id_rt_val,
	output word_t    id_imm,
	output reg_idx_t id_rs,
	output reg_idx_t id_rt,
	output reg_idx_t id_rd,
	output logic     id_regdst,
	output logic     id_alusrc,
	output logic     id_memread,
	output logic     id_memwrite,
	output logic     id_memtoreg,
	output logic     id_regwrite,
	output logic     id_beq,
	output logic     id_bne,
	output alu_op_t  id_aluop
);

	word_t    regs [`MIPS_NREG];
	reg_idx_t rs;
	reg_idx_t rt;
	word_t    imm_sx;
	word_t    rs_val;
	word_t    rt_val;

	// decoded control levels
	logic    regdst;
	logic    alusrc;
	logic    memread;
	logic    memwrite;
	logic    memtoreg;
	logic    regwrite;
	logic    beq;
	logic    bne;
	alu_op_t aluop;

	// operand fields through the I view, rd through the R view
	assign rs = if_instr.i.rs;
	assign rt = if_instr.i.rt;
	assign imm_sx = {{(`MIPS_XLEN-16){if_instr.i.imm[15]}}, if_instr.i.imm};

	// r0 reads zero, a write in the same cycle is passed straight through
	function automatic word_t read_reg(input reg_idx_t idx);
		word_t val;
		if (idx == '0)
			val = '0;
		else if (wb_we && wb_reg == idx)
			val = wb_data;
		else
			val = regs[idx];
		return val;
	endfunction

	assign rs_val = read_reg(rs);
	assign rt_val = read_reg(rt);

	// writes to r0 are dropped
	always_ff @(posedge clk) begin
		if (wb_we && wb_reg != '0)
			regs[wb_reg] <= wb_data;
	end

	// main control, unknown opcodes fall through as a no-op
	always_comb begin
		regdst   = 1'b0;
		alusrc   = 1'b0;
		memread  = 1'b0;
		memwrite = 1'b0;
		memtoreg = 1'b0;
		regwrite = 1'b0;
		beq      = 1'b0;
		bne      = 1'b0;
		aluop    = mem_add;
		case (if_instr.i.opcode)
			`OP_RTYPE: begin
				regdst   = 1'b1;
				regwrite = 1'b1;
				aluop    = funct;
			end
			`OP_LW: begin
				alusrc   = 1'b1;
				memread  = 1'b1;
				memtoreg = 1'b1;
				regwrite = 1'b1;
			end
			`OP_SW: begin
				alusrc   = 1'b1;
				memwrite = 1'b1;
			end
			`OP_ADDI: begin
				alusrc   = 1'b1;
				regwrite = 1'b1;
				aluop    = imm_add;
			end
			`OP_BEQ: begin
				beq   = 1'b1;
				aluop = br_sub;
			end
			`OP_BNE: begin
				bne   = 1'b1;
				aluop = br_sub;
			end
			default: ;
		endcase
	end

	// load in execute whose target feeds the instruction here
	assign stall = id_memread && (id_rt == rs || id_rt == rt);

	// ID/EX control, a bubble on stall or a taken branch
	always_ff @(posedge clk) begin
		if (rst || flush || stall) begin
			id_regdst   <= 1'b0;
			id_alusrc   <= 1'b0;
			id_memread  <= 1'b0;
			id_memwrite <= 1'b0;
			id_memtoreg <= 1'b0;
			id_regwrite <= 1'b0;
			id_beq      <= 1'b0;
			id_bne      <= 1'b0;
			id_aluop    <= mem_add;
		end else begin
			id_regdst   <= regdst;
			id_alusrc   <= alusrc;
			id_memread  <= memread;
			id_memwrite <= memwrite;
			id_memtoreg <= memtoreg;
			id_regwrite <= regwrite;
			id_beq      <= beq;
			id_bne      <= bne;
			id_aluop    <= aluop;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		id_pc4    <= if_pc4;
		id_rs_val <= rs_val;
		id_rt_val <= rt_val;
		id_imm    <= imm_sx;
		id_rs     <= rs;
		id_rt     <= rt;
		id_rd     <= if_instr.r.rd;
	end

endmodule

// File: rtl/execute_stage.sv
// operand forwarding, ALU and branch target, ending in the EX/MEM register
module execute_stage import mips_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     flush,
	input  word_t    id_pc4,
	input  word_t    id_rs_val,
	input  word_t    id_rt_val,
	input  word_t    id_imm,
	input  reg_idx_t id_rs,
	input  reg_idx_t id_rt,
	input  reg_idx_t id_rd,
	input  logic     id_regdst,
	input  logic     id_alusrc,
	input  logic     id_memread,
	input  logic     id_memwrite,
	input  logic     id_memtoreg,
	input  logic     id_regwrite,
	input  logic     id_beq,
	input  logic     id_bne,
	input  alu_op_t  id_aluop,
	input  logic     wb_we,
	input  reg_idx_t wb_reg,
	input  word_t    wb_data,
	output word_t    ex_result,
	output word_t    ex_store,
	output word_t    ex_target,
	output reg_idx_t ex_reg,
	output logic     ex_zero,
	output logic     ex_regwrite,
	output logic     ex_memread,
	output logic     ex_memwrite,
	output logic     ex_memtoreg,
	output logic     ex_beq,
	output logic     ex_bne
);

	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	word_t    op_a;
	word_t    op_b;
	word_t    alu_b;
	word_t    alu_out;
	alu_ctl_t alu_ctl;

	// newest producer first, r0 never forwarded
	function automatic fwd_sel_t pick_src(input reg_idx_t idx);
		fwd_sel_t sel;
		if (idx == '0)
			sel = fwd_none;
		else if (ex_regwrite && ex_reg == idx)
			sel = fwd_mem;
		else if (wb_we && wb_reg == idx)
			sel = fwd_wb;
		else
			sel = fwd_none;
		return sel;
	endfunction

	function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val);
		word_t val;
		case (sel)
			fwd_mem: val = ex_result;
			fwd_wb:  val = wb_data;
			default: val = reg_val;
		endcase
		return val;
	endfunction

	assign fwd_a = pick_src(id_rs);
	assign fwd_b = pick_src(id_rt);
	assign op_a = fwd_mux(fwd_a, id_rs_val);
	assign op_b = fwd_mux(fwd_b, id_rt_val);
	assign alu_b = id_alusrc ? id_imm : op_b;

	// function field sits in the low bits of the immediate
	always_comb begin
		case (id_aluop)
			br_sub: alu_ctl = alu_sub;
			funct: begin
				case (id_imm[3:0])
					4'd0:    alu_ctl = alu_add;
					4'd2:    alu_ctl = alu_sub;
					4'd5:    alu_ctl = alu_or;
					4'd6:    alu_ctl = alu_xor;
					4'd7:    alu_ctl = alu_nor;
					4'd10:   alu_ctl = alu_slt;
					default: alu_ctl = alu_and;
				endcase
			end
			default: alu_ctl = alu_add;
		endcase
	end

	always_comb begin
		case (alu_ctl)
			alu_add: alu_out = op_a + alu_b;
			alu_sub: alu_out = op_a - alu_b;
			alu_or:  alu_out = op_a | alu_b;
			alu_xor: alu_out = op_a ^ alu_b;
			alu_nor: alu_out = ~(op_a | alu_b);
			// signed compare, no overflow path needed
			alu_slt: alu_out = word_t'($signed(op_a) < $signed(alu_b));
			default: alu_out = op_a & alu_b;
		endcase
	end

	// EX/MEM control, squashed behind a taken branch
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ex_regwrite <= 1'b0;
			ex_memread  <= 1'b0;
			ex_memwrite <= 1'b0;
			ex_memtoreg <= 1'b0;
			ex_beq      <= 1'b0;
			ex_bne      <= 1'b0;
		end else begin
			ex_regwrite <= id_regwrite;
			ex_memread  <= id_memread;
			ex_memwrite <= id_memwrite;
			ex_memtoreg <= id_memtoreg;
			ex_beq      <= id_beq;
			ex_bne      <= id_bne;
		end
	end

	// EX/MEM payload
	always_ff @(posedge clk) begin
		ex_result <= alu_out;
		ex_store  <= op_b;
		ex_zero   <= (alu_out == '0);
		ex_reg    <= id_regdst ? id_rd : id_rt;
		// word offset scaled to bytes
		ex_target <= id_pc4 + {id_imm[$bits(word_t)-3:0], 2'b00};
	end

endmodule

// File: rtl/fetch_stage.sv
// program counter and IF/ID register, fed by an external instruction port
module fetch_stage import mips_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   stall,
	input  logic   redirect,
	input  word_t  redirect_pc,
	input  logic   flush,
	input  word_t  imem_data,
	output word_t  imem_addr,
	output word_t  if_pc4,
	output instr_t if_instr
);

	word_t pc;
	word_t pc4;

	// fetch address is the PC itself
	assign imem_addr = pc;
	assign pc4 = pc + 32'd4;

	// taken branch wins over a load-use hold
	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (redirect)
			pc <= redirect_pc;
		else if (!stall)
			pc <= pc4;
	end

	// IF/ID, all-zero word decodes as a no-op
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			if_pc4   <= '0;
			if_instr <= '0;
		end else if (!stall) begin
			if_pc4   <= pc4;
			if_instr <= imem_data;
		end
	end

endmodule

// File: rtl/mem_wb_stage.sv
// data port drive, branch decision, MEM/WB register and writeback select
`include "mips_params.svh"

module mem_wb_stage import mips_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  word_t                    ex_result,
	input  word_t                    ex_store,
	input  word_t                    ex_target,
	input  reg_idx_t                 ex_reg,
	input  logic                     ex_zero,
	input  logic                     ex_regwrite,
	input  logic                     ex_memread,
	input  logic                     ex_memwrite,
	input  logic                     ex_memtoreg,
	input  logic                     ex_beq,
	input  logic                     ex_bne,
	input  word_t                    dmem_rdata,
	output logic [`MIPS_DADDR_W-1:0] dmem_addr,
	output word_t                    dmem_wdata,
	output logic                     dmem_we,
	output logic                     redirect,
	output word_t                    redirect_pc,
	output logic                     flush,
	output logic                     wb_we,
	output reg_idx_t                 wb_reg,
	output word_t                    wb_data
);

	logic  wb_memtoreg;
	word_t wb_load;
	word_t wb_result;

	// byte address to word index
	assign dmem_addr = ex_result[`MIPS_DADDR_W+1:2];
	assign dmem_wdata = ex_store;
	assign dmem_we = ex_memwrite;

	// branch resolves here, three younger slots get squashed
	assign redirect = (ex_beq && ex_zero) || (ex_bne && !ex_zero);
	assign redirect_pc = ex_target;
	assign flush = redirect;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_we       <= 1'b0;
			wb_memtoreg <= 1'b0;
		end else begin
			wb_we       <= ex_regwrite;
			wb_memtoreg <= ex_memtoreg;
		end
	end

	// load data only captured when a read is in flight
	always_ff @(posedge clk) begin
		wb_reg    <= ex_reg;
		wb_result <= ex_result;
		if (ex_memread)
			wb_load <= dmem_rdata;
	end

	assign wb_data = wb_memtoreg ? wb_load : wb_result;

endmodule

// File: rtl/mips_core.sv
// five-stage core top, instruction and data memories sit outside on plain ports
`include "mips_params.svh"

module mips_core import mips_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	output word_t                    imem_addr,
	input  word_t                    imem_data,
	output logic [`MIPS_DADDR_W-1:0] dmem_addr,
	output word_t                    dmem_wdata,
	output logic                     dmem_we,
	input  word_t                    dmem_rdata
);

	// hazard and redirect levels
	logic     stall;
	logic     redirect;
	logic     flush;
	word_t    redirect_pc;
	// IF/ID
	word_t    if_pc4;
	instr_t   if_instr;
	// ID/EX
	word_t    id_pc4, id_rs_val, id_rt_val, id_imm;
	reg_idx_t id_rs, id_rt, id_rd;
	logic     id_regdst, id_alusrc, id_memread, id_memwrite;
	logic     id_memtoreg, id_regwrite, id_beq, id_bne;
	alu_op_t  id_aluop;
	// EX/MEM
	word_t    ex_result, ex_store, ex_target;
	reg_idx_t ex_reg;
	logic     ex_zero, ex_regwrite, ex_memread, ex_memwrite;
	logic     ex_memtoreg, ex_beq, ex_bne;
	// writeback
	logic     wb_we;
	reg_idx_t wb_reg;
	word_t    wb_data;

	fetch_stage u_fetch (.*);

	decode_stage u_decode (.*);

	execute_stage u_execute (.*);

	mem_wb_stage u_mem_wb (.*);

endmodule

// File: rtl/mips_params.svh
// widths, register count and instruction encodings for the core and its testbench
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath and address width
`define MIPS_XLEN 32
// register file size and index width
`define MIPS_NREG 32
`define MIPS_RIDX 5
// data memory word index, taken from result bits 8 to 2
`define MIPS_DADDR_W 7

// opcodes of the supported subset
`define OP_RTYPE 6'h00
`define OP_LW    6'h23
`define OP_SW    6'h2b
`define OP_ADDI  6'h08
`define OP_BEQ   6'h04
`define OP_BNE   6'h05

// R-type function codes
// execute only looks at the low nibble
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_XOR 6'h26
`define FN_NOR 6'h27
`define FN_SLT 6'h2a

`endif

// File: rtl/mips_pkg.sv
// shared types for the pipeline stages, imported by every RTL module
`include "mips_params.svh"

package mips_pkg;

	// one data or address word
	typedef logic [`MIPS_XLEN-1:0] word_t;
	// register file index
	typedef logic [`MIPS_RIDX-1:0] reg_idx_t;

	// register-register layout
	typedef struct packed {
		logic [5:0] opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	// immediate layout, also used for loads, stores and branches
	typedef struct packed {
		logic [5:0]  opcode;
		reg_idx_t    rs;
		reg_idx_t    rt;
		logic [15:0] imm;
	} i_fmt_t;

	// same instruction word seen through either layout
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	// ALU operation select
	typedef enum logic [3:0] {
		alu_and = 4'd0,
		alu_or  = 4'd1,
		alu_add = 4'd2,
		alu_sub = 4'd6,
		alu_slt = 4'd7,
		alu_nor = 4'd12,
		alu_xor = 4'd13
	} alu_ctl_t;

	// coarse ALU class from decode, refined in execute
	typedef enum logic [1:0] {
		mem_add = 2'd0,
		br_sub  = 2'd1,
		funct   = 2'd2,
		imm_add = 2'd3
	} alu_op_t;

	// operand source in execute
	typedef enum logic [1:0] {
		fwd_none = 2'd0,
		fwd_mem  = 2'd1,
		fwd_wb   = 2'd2
	} fwd_sel_t;

endpackage

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mips_core_tb -f all.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }

// File: tests/mips_core_asserts.sv
// concurrent checks on reset, stall and redirect behavior, bound into mips_core
module mips_core_asserts (
	input logic clk,
	input logic rst,
	input logic dmem_we,
	input logic stall,
	input logic redirect
);

	timeunit 1ns;
	timeprecision 100ps;

	// no store may leave the core while reset is held
	assert property (@(posedge clk) (rst && $past(rst)) |-> !dmem_we)
		else $error("dmem_we high during reset");

	// load-use costs exactly one bubble
	assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
		else $error("stall held for two cycles");

	// squashed slots must never reach the data port
	assert property (@(posedge clk) disable iff (rst)
		!(dmem_we && ($past(redirect, 1) || $past(redirect, 2) || $past(redirect, 3))))
		else $error("store issued within three cycles of a redirect");

endmodule

// stall and redirect are internal nets of the core
bind mips_core mips_core_asserts u_asserts (
	.clk      (clk),
	.rst      (rst),
	.dmem_we  (dmem_we),
	.stall    (stall),
	.redirect (redirect)
);

// File: tests/mips_core_tb.sv
// directed testbench that models both memories around mips_core and checks the logged stores
`include "mips_params.svh"

module mips_core_tb import mips_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic                     clk;
	logic                     rst;
	word_t                    imem_addr;
	word_t                    imem_data;
	logic [`MIPS_DADDR_W-1:0] dmem_addr;
	word_t                    dmem_wdata;
	logic                     dmem_we;
	word_t                    dmem_rdata;

	word_t      imem [256];
	word_t      dmem [128];
	word_t      log_addr [$];
	word_t      log_data [$];
	logic [7:0] pc_idx;
	int         errors;
	int         checks;

	mips_core dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// both memories answer in the same cycle
	assign imem_data = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr];

	// write and log every store including those during reset
	always @(posedge clk) begin
		if (dmem_we === 1'b1) begin
			dmem[dmem_addr] <= dmem_wdata;
			log_addr.push_back(word_t'(dmem_addr));
			log_data.push_back(dmem_wdata);
		end
	end

	task automatic compare_word(input string msg, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	// k-th logged store against a word index and data
	task automatic expect_store(input int k, input word_t idx, input word_t data);
		if (k >= log_data.size()) begin
			errors++;
			$display("store %0d was never logged", k);
		end else begin
			compare_word($sformatf("store %0d address", k), log_addr[k], idx);
			compare_word($sformatf("store %0d data", k), log_data[k], data);
		end
	endtask

	task automatic emit_r(input logic [5:0] fn, input reg_idx_t rd, input reg_idx_t rs,
			input reg_idx_t rt);
		imem[pc_idx] = {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
		pc_idx++;
	endtask

	task automatic emit_i(input logic [5:0] op, input reg_idx_t rt, input reg_idx_t rs,
			input logic [15:0] imm);
		imem[pc_idx] = {op, rs, rt, imm};
		pc_idx++;
	endtask

	// branch to itself parks the core
	task automatic emit_halt();
		emit_i(`OP_BEQ, 5'd0, 5'd0, 16'hffff);
	endtask

	// holds reset and clears the program and the store log
	task automatic begin_program();
		@(posedge clk);
		#1;
		rst = 1'b1;
		for (int i = 0; i < 256; i++)
			imem[i[7:0]] = '0;
		pc_idx = '0;
		log_addr.delete();
		log_data.delete();
	endtask

	task automatic release_reset();
		repeat (8) @(posedge clk);
		#1;
		// fetch starts from address 0
		compare_word("fetch address after reset", imem_addr, 32'd0);
		rst = 1'b0;
	endtask

	// waits for n stores and then idles so that stray stores show up
	task automatic wait_stores(input int n);
		int cycles;
		cycles = 0;
		while (log_data.size() < n && cycles < 300) begin
			@(posedge clk);
			cycles++;
		end
		if (log_data.size() < n) begin
			errors++;
			$display("timeout waiting for %0d stores, saw %0d", n, log_data.size());
		end
		repeat (16) @(posedge clk);
		compare_word("store count", word_t'(log_data.size()), word_t'(n));
	endtask

	task automatic test_alu();
		word_t       a;
		word_t       b;
		word_t       cx;
		logic [15:0] c;
		word_t       exp [9];
		begin_program();
		a = $urandom;
		b = $urandom;
		c = 16'($urandom);
		cx = {{16{c[15]}}, c};
		dmem[0] = a;
		dmem[1] = b;
		emit_i(`OP_LW, 5'd1, 5'd0, 16'd0);
		emit_i(`OP_LW, 5'd2, 5'd0, 16'd4);
		emit_i(`OP_ADDI, 5'd3, 5'd0, c);
		emit_r(`FN_ADD, 5'd4, 5'd1, 5'd2);
		emit_i(`OP_SW, 5'd4, 5'd0, 16'd64);
		emit_r(`FN_SUB, 5'd5, 5'd1, 5'd2);
		emit_i(`OP_SW, 5'd5, 5'd0, 16'd68);
		emit_r(`FN_AND, 5'd6, 5'd1, 5'd2);
		emit_i(`OP_SW, 5'd6, 5'd0, 16'd72);
		emit_r(`FN_OR, 5'd7, 5'd1, 5'd2);
		emit_i(`OP_SW, 5'd7, 5'd0, 16'd76);
		emit_r(`FN_XOR, 5'd8, 5'd1, 5'd2);
		emit_i(`OP_SW, 5'd8, 5'd0, 16'd80);
		emit_r(`FN_NOR, 5'd9, 5'd1, 5'd2);
		emit_i(`OP_SW, 5'd9, 5'd0, 16'd84);
		emit_r(`FN_SLT, 5'd10, 5'd1, 5'd2);
		emit_i(`OP_SW, 5'd10, 5'd0, 16'd88);
		emit_r(`FN_SLT, 5'd11, 5'd3, 5'd1);
		emit_i(`OP_SW, 5'd11, 5'd0, 16'd92);
		emit_r(`FN_ADD, 5'd12, 5'd1, 5'd3);
		emit_i(`OP_SW, 5'd12, 5'd0, 16'd96);
		emit_halt();
		release_reset();
		exp[0] = a + b;
		exp[1] = a - b;
		exp[2] = a & b;
		exp[3] = a | b;
		exp[4] = a ^ b;
		exp[5] = ~(a | b);
		// signed compares
		exp[6] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		exp[7] = ($signed(cx) < $signed(a)) ? 32'd1 : 32'd0;
		exp[8] = a + cx;
		wait_stores(9);
		for (int k = 0; k < 9; k++)
			expect_store(k, word_t'(16 + k), exp[k]);
	endtask

	// dependent chain back to back and then spaced by no-ops
	task automatic test_forward();
		logic [15:0] x;
		word_t       xs;
		begin_program();
		x = 16'($urandom);
		xs = {{16{x[15]}}, x};
		emit_i(`OP_ADDI, 5'd1, 5'd0, x);
		emit_r(`FN_ADD, 5'd2, 5'd1, 5'd1);
		emit_r(`FN_XOR, 5'd3, 5'd2, 5'd1);
		emit_i(`OP_SW, 5'd3, 5'd0, 16'd0);
		emit_i(`OP_ADDI, 5'd7, 5'd0, x);
		pc_idx += 8'd3;
		emit_r(`FN_ADD, 5'd8, 5'd7, 5'd7);
		pc_idx += 8'd3;
		emit_r(`FN_XOR, 5'd9, 5'd8, 5'd7);
		pc_idx += 8'd3;
		emit_i(`OP_SW, 5'd9, 5'd0, 16'd4);
		emit_halt();
		release_reset();
		wait_stores(2);
		expect_store(0, 32'd0, (xs + xs) ^ xs);
		expect_store(1, 32'd1, (xs + xs) ^ xs);
	endtask

	task automatic test_load_use();
		word_t       v;
		logic [15:0] k;
		begin_program();
		v = $urandom;
		k = 16'($urandom);
		dmem[5] = v;
		emit_i(`OP_ADDI, 5'd1, 5'd0, k);
		emit_i(`OP_LW, 5'd2, 5'd0, 16'd20);
		emit_r(`FN_ADD, 5'd3, 5'd2, 5'd1);
		emit_i(`OP_SW, 5'd3, 5'd0, 16'd8);
		emit_halt();
		release_reset();
		wait_stores(1);
		expect_store(0, 32'd2, v + {{16{k[15]}}, k});
	endtask

	// taken branches skip three store slots aimed at word 30
	task automatic test_branch();
		begin_program();
		emit_i(`OP_ADDI, 5'd1, 5'd0, 16'd5);
		emit_i(`OP_ADDI, 5'd2, 5'd0, 16'd5);
		emit_i(`OP_ADDI, 5'd3, 5'd0, 16'd7);
		emit_i(`OP_BEQ, 5'd2, 5'd1, 16'd3);
		for (int i = 0; i < 3; i++)
			emit_i(`OP_SW, 5'd3, 5'd0, 16'd120);
		emit_i(`OP_SW, 5'd1, 5'd0, 16'd32);
		emit_i(`OP_BNE, 5'd2, 5'd1, 16'd3);
		emit_i(`OP_SW, 5'd2, 5'd0, 16'd36);
		emit_i(`OP_BEQ, 5'd3, 5'd1, 16'd3);
		emit_i(`OP_SW, 5'd3, 5'd0, 16'd40);
		emit_i(`OP_BNE, 5'd3, 5'd1, 16'd3);
		for (int i = 0; i < 3; i++)
			emit_i(`OP_SW, 5'd3, 5'd0, 16'd120);
		emit_i(`OP_SW, 5'd3, 5'd0, 16'd44);
		emit_halt();
		release_reset();
		wait_stores(4);
		expect_store(0, 32'd8, 32'd5);
		expect_store(1, 32'd9, 32'd5);
		expect_store(2, 32'd10, 32'd7);
		expect_store(3, 32'd11, 32'd7);
	endtask

	// r0 stays zero whether read through forwarding or the file
	task automatic test_reg_zero();
		begin_program();
		emit_i(`OP_ADDI, 5'd1, 5'd0, 16'd9);
		emit_i(`OP_ADDI, 5'd0, 5'd0, 16'd123);
		emit_i(`OP_SW, 5'd0, 5'd0, 16'd48);
		emit_r(`FN_ADD, 5'd0, 5'd1, 5'd1);
		pc_idx += 8'd1;
		emit_i(`OP_SW, 5'd0, 5'd0, 16'd52);
		pc_idx += 8'd3;
		emit_i(`OP_SW, 5'd0, 5'd0, 16'd56);
		emit_halt();
		release_reset();
		wait_stores(3);
		expect_store(0, 32'd12, 32'd0);
		expect_store(1, 32'd13, 32'd0);
		expect_store(2, 32'd14, 32'd0);
	endtask

	initial begin
		rst = 1'b1;
		errors = 0;
		checks = 0;
		pc_idx = '0;
		void'($urandom(32'h3a43ee87));
		for (int i = 0; i < 128; i++)
			dmem[i[6:0]] = '0;
		test_alu();
		test_forward();
		test_load_use();
		test_branch();
		test_reg_zero();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
